// File: project.f
common/switch_pkg.sv
resp_queue/flit_fifo.sv
resp_queue/resp_queue.sv
arbiter/rr_arbiter.sv
arbiter/resp_scheduler.sv
source/dest_router.sv
source/switch_top.sv
sim/clock_gen.sv
sim/switch_tb.sv

// File: Bender.yml
package:
  name: noc_switch

sources:
  # shared package first
  - common/switch_pkg.sv
  # response queues
  - resp_queue/flit_fifo.sv
  - resp_queue/resp_queue.sv
  # response scheduling
  - arbiter/rr_arbiter.sv
  - arbiter/resp_scheduler.sv
  # request path and top level
  - source/dest_router.sv
  - source/switch_top.sv
  # testbench
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/switch_tb.sv

// File: sim/switch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module switch_tb import switch_pkg::*; ();

	localparam int FIFO_DEPTH = 16;
	localparam int MAX_REQ = 64;
	localparam int MAX_RESP = 32;
	localparam int NUM_BATCH = 10;
	localparam logic [31:0] SEED = 32'h11d0_c80f;

	logic to;
	logic rst_n;
	logic noc_to_dev_ctl;
	logic [BYTE_W-1:0] noc_to_dev_data;
	logic [NUM_PORTS-1:0] dev_tx_ctl;
	logic [NUM_PORTS-1:0][BYTE_W-1:0] dev_tx_data;
	logic [NUM_PORTS-1:0] dev_rx_ctl;
	logic [NUM_PORTS-1:0][BYTE_W-1:0] dev_rx_data;
	logic noc_from_dev_ctl;
	logic [BYTE_W-1:0] noc_from_dev_data;

	// request table, one stream byte per row with the port it must reach
	logic req_ctl [MAX_REQ];
	logic [BYTE_W-1:0] req_data [MAX_REQ];
	int req_port [MAX_REQ];
	int n_req = 0;

	// response table, one packet per row
	int rsp_port [MAX_RESP];
	int rsp_batch [MAX_RESP];
	logic rsp_read [MAX_RESP];
	int rsp_len [MAX_RESP];
	int rsp_start [MAX_RESP];
	flit_t rsp_bytes [MAX_RESP][8];
	int n_resp = 0;
	int batch_span [NUM_BATCH];

	// predicted outbound packet order, as response table rows
	int resp_order [$];
	int exp_count = 0;
	int out_got = 0;
	// arbiter pointers of the model, both favour port 0 after reset
	int hi_ptr = 0;
	int lo_ptr = 0;
	bit tables_built = 1'b0;

	clock_gen #(
		.PERIOD       (100),
		.RESET_CYCLES (3)
	) i_clock_gen (
		.to    (to),
		.rst_n (rst_n)
	);

	switch_top #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_switch_top (
		.to                (to),
		.rst_n             (rst_n),
		.noc_to_dev_ctl    (noc_to_dev_ctl),
		.noc_to_dev_data   (noc_to_dev_data),
		.dev_tx_ctl        (dev_tx_ctl),
		.dev_tx_data       (dev_tx_data),
		.dev_rx_ctl        (dev_rx_ctl),
		.dev_rx_data       (dev_rx_data),
		.noc_from_dev_ctl  (noc_from_dev_ctl),
		.noc_from_dev_data (noc_from_dev_data)
	);

	task automatic stop_on_error();
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	// one device transmit port against its expected byte
	task automatic check_port_flit(input int port, input logic ctl,
			input logic [BYTE_W-1:0] data);
		if (dev_tx_ctl[port] !== ctl || dev_tx_data[port] !== data) begin
			$display("Mismatch at %0t ns: port %0d expected ctl %b data %h, got ctl %b data %h",
				$time, port, ctl, data, dev_tx_ctl[port], dev_tx_data[port]);
			stop_on_error();
		end
	endtask

	// outbound response stream against its expected byte
	task automatic check_out_flit(input logic ctl, input logic [BYTE_W-1:0] data);
		if (noc_from_dev_ctl !== ctl || noc_from_dev_data !== data) begin
			$display("Mismatch at %0t ns: outbound expected ctl %b data %h, got ctl %b data %h",
				$time, ctl, data, noc_from_dev_ctl, noc_from_dev_data);
			stop_on_error();
		end
	endtask

	task automatic push_request_byte(input logic ctl, input logic [BYTE_W-1:0] data,
			input int port);
		req_ctl[n_req] = ctl;
		req_data[n_req] = data;
		req_port[n_req] = port;
		n_req++;
	endtask

	// command, destination, payload, closing nop and one idle nop
	task automatic add_request(input logic [BYTE_W-1:0] dest);
		int port;
		int len;
		port = -1;
		if (dest >= DEV_ID_BASE && dest < DEV_ID_BASE + BYTE_W'(NUM_PORTS))
			port = int'(dest - DEV_ID_BASE);
		len = 1 + int'($urandom % 6);
		push_request_byte(1'b1, {5'($urandom), 3'b001}, port);
		push_request_byte(1'b0, dest, port);
		for (int i = 0; i < len; i++)
			push_request_byte(1'b0, 8'($urandom), port);
		// nops read the same on every port
		push_request_byte(1'b1, NOP_DATA, -1);
		push_request_byte(1'b1, NOP_DATA, -1);
	endtask

	task automatic add_response(input int batch, input int port, input logic read);
		int len;
		logic [2:0] op;
		len = 1 + int'($urandom % 6);
		// 011b marks a read response, write response stands for the rest
		op = read ? 3'b011 : 3'b100;
		rsp_port[n_resp] = port;
		rsp_batch[n_resp] = batch;
		rsp_read[n_resp] = read;
		rsp_len[n_resp] = len;
		rsp_bytes[n_resp][0] = {1'b1, 5'($urandom), op};
		for (int i = 1; i <= len; i++)
			rsp_bytes[n_resp][i] = {1'b0, 8'($urandom)};
		rsp_bytes[n_resp][len + 1] = {1'b1, NOP_DATA};
		n_resp++;
	endtask

	// packets of one batch all end on the same cycle
	task automatic place_in_time();
		for (int b = 0; b < NUM_BATCH; b++) begin
			batch_span[b] = 0;
			for (int r = 0; r < n_resp; r++)
				if (rsp_batch[r] == b && rsp_len[r] + 2 > batch_span[b])
					batch_span[b] = rsp_len[r] + 2;
			for (int r = 0; r < n_resp; r++)
				if (rsp_batch[r] == b)
					rsp_start[r] = batch_span[b] - (rsp_len[r] + 2);
		end
	endtask

	// reads first, round robin per class from just past the last grant
	task automatic predict_batch_order(input int b);
		bit pending [NUM_PORTS];
		bit is_read [NUM_PORTS];
		int row [NUM_PORTS];
		int left;
		int port;
		bit any_hi;
		bit found;
		left = 0;
		for (int k = 0; k < NUM_PORTS; k++)
			pending[k] = 1'b0;
		for (int r = 0; r < n_resp; r++) begin
			if (rsp_batch[r] == b) begin
				pending[rsp_port[r]] = 1'b1;
				is_read[rsp_port[r]] = rsp_read[r];
				row[rsp_port[r]] = r;
				left++;
			end
		end
		while (left > 0) begin
			any_hi = 1'b0;
			for (int k = 0; k < NUM_PORTS; k++)
				if (pending[k] && is_read[k])
					any_hi = 1'b1;
			found = 1'b0;
			port = 0;
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (!found && pending[((any_hi ? hi_ptr : lo_ptr) + i) % NUM_PORTS] &&
						is_read[((any_hi ? hi_ptr : lo_ptr) + i) % NUM_PORTS] == any_hi) begin
					port = ((any_hi ? hi_ptr : lo_ptr) + i) % NUM_PORTS;
					found = 1'b1;
				end
			end
			resp_order.push_back(row[port]);
			exp_count++;
			pending[port] = 1'b0;
			left--;
			if (any_hi)
				hi_ptr = (port + 1) % NUM_PORTS;
			else
				lo_ptr = (port + 1) % NUM_PORTS;
		end
	endtask

	task automatic drive_batch(input int b);
		logic [NUM_PORTS-1:0] v_ctl;
		logic [NUM_PORTS-1:0][BYTE_W-1:0] v_data;
		int off;
		for (int c = 0; c < batch_span[b]; c++) begin
			v_ctl = '1;
			v_data = '0;
			for (int r = 0; r < n_resp; r++) begin
				off = c - rsp_start[r];
				if (rsp_batch[r] == b && off >= 0 && off <= rsp_len[r] + 1) begin
					v_ctl[rsp_port[r]] = rsp_bytes[r][off].ctl;
					v_data[rsp_port[r]] = rsp_bytes[r][off].data;
				end
			end
			@(posedge to);
			dev_rx_ctl <= v_ctl;
			dev_rx_data <= v_data;
		end
	endtask

	initial begin : stimulus
		noc_to_dev_ctl = 1'b1;
		noc_to_dev_data = NOP_DATA;
		dev_rx_ctl = '1;
		dev_rx_data = '0;
		void'($urandom(SEED));
		// every device id, then one id past the last port
		for (int k = 0; k <= NUM_PORTS; k++)
			add_request(DEV_ID_BASE + BYTE_W'(k));
		// lone ordinary packets, port by port
		for (int k = 0; k < NUM_PORTS; k++)
			add_response(k, k, 1'b0);
		// full rounds, a lone packet on port 1 shifts the third one
		for (int k = 0; k < NUM_PORTS; k++) begin
			add_response(4, k, 1'b0);
			add_response(5, k, 1'b0);
			add_response(7, k, 1'b0);
		end
		add_response(6, 1, 1'b0);
		// read responses overtake ordinary ones
		add_response(8, 0, 1'b0);
		add_response(8, 2, 1'b1);
		for (int k = 0; k < NUM_PORTS; k++)
			add_response(9, k, logic'(k % 2));
		place_in_time();
		tables_built = 1'b1;

		wait (rst_n === 1'b1);
		@(negedge to);
		for (int k = 0; k < NUM_PORTS; k++)
			check_port_flit(k, 1'b1, NOP_DATA);
		check_out_flit(1'b1, NOP_DATA);

		// byte driven at edge t shows on its port after edge t+2
		for (int t = 0; t < n_req + 2; t++) begin
			@(posedge to);
			noc_to_dev_ctl <= (t < n_req) ? req_ctl[t] : 1'b1;
			noc_to_dev_data <= (t < n_req) ? req_data[t] : NOP_DATA;
			@(negedge to);
			if (t >= 2) begin
				for (int k = 0; k < NUM_PORTS; k++) begin
					if (req_port[t - 2] == k)
						check_port_flit(k, req_ctl[t - 2], req_data[t - 2]);
					else
						check_port_flit(k, 1'b1, NOP_DATA);
				end
			end
		end

		// next batch only once the monitor has seen the last one
		for (int b = 0; b < NUM_BATCH; b++) begin
			predict_batch_order(b);
			drive_batch(b);
			wait (out_got == exp_count);
		end
		repeat (4) @(posedge to);
		$display("Finished with no errors");
		$finish;
	end

	// outbound stream, nop between packets, packets in predicted order
	initial begin : out_monitor
		int pos;
		int r;
		logic in_pkt;
		pos = 0;
		in_pkt = 1'b0;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge to);
			if (!in_pkt && noc_from_dev_ctl === 1'b1 && noc_from_dev_data !== NOP_DATA) begin
				if (out_got >= exp_count) begin
					$display("Mismatch at %0t ns: outbound command %h with no packet expected",
						$time, noc_from_dev_data);
					stop_on_error();
				end
				in_pkt = 1'b1;
				pos = 0;
			end
			if (in_pkt) begin
				r = resp_order[out_got];
				check_out_flit(rsp_bytes[r][pos].ctl, rsp_bytes[r][pos].data);
				if (pos == rsp_len[r] + 1) begin
					in_pkt = 1'b0;
					out_got++;
				end else begin
					pos++;
				end
			end else begin
				check_out_flit(1'b1, NOP_DATA);
			end
		end
	end

	// run limit grows with the table length
	initial begin : watchdog
		int limit;
		wait (tables_built);
		limit = 60 * (n_req + n_resp) + 200;
		repeat (limit) @(posedge to);
		$display("Timeout: the test did not complete within %0d clock cycles", limit);
		stop_on_error();
	end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic to,
	output logic rst_n
);

	// free running clock, starts low
	initial begin
		to = 1'b0;
		forever #(PERIOD / 2) to = ~to;
	end

	// reset held low over the first rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge to);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: source/switch_top.sv
`timescale 1ns/1ns
`default_nettype none

module switch_top import switch_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input wire logic to,
	input wire logic rst_n,
	// request stream from the noc
	input wire logic noc_to_dev_ctl,
	input wire logic [BYTE_W-1:0] noc_to_dev_data,
	// per device transmit side
	output logic [NUM_PORTS-1:0] dev_tx_ctl,
	output logic [NUM_PORTS-1:0][BYTE_W-1:0] dev_tx_data,
	// per device return side
	input wire logic [NUM_PORTS-1:0] dev_rx_ctl,
	input wire logic [NUM_PORTS-1:0][BYTE_W-1:0] dev_rx_data,
	// merged response stream back to the noc
	output logic noc_from_dev_ctl,
	output logic [BYTE_W-1:0] noc_from_dev_data
);

	// queue status and head flits seen by the scheduler
	port_sel_t pkt_ready;
	port_sel_t pkt_is_read;
	port_sel_t pop;
	flit_t [NUM_PORTS-1:0] head;

	// request path, two cycle steering to the addressed device
	dest_router i_dest_router (
		.to              (to),
		.rst_n           (rst_n),
		.noc_to_dev_ctl  (noc_to_dev_ctl),
		.noc_to_dev_data (noc_to_dev_data),
		.dev_tx_ctl      (dev_tx_ctl),
		.dev_tx_data     (dev_tx_data)
	);

	// one packet queue per device return stream
	for (genvar k = 0; k < NUM_PORTS; k++) begin : g_queue
		resp_queue #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) i_resp_queue (
			.to          (to),
			.rst_n       (rst_n),
			.dev_rx_ctl  (dev_rx_ctl[k]),
			.dev_rx_data (dev_rx_data[k]),
			.pop         (pop[k]),
			.head        (head[k]),
			.pkt_ready   (pkt_ready[k]),
			.pkt_is_read (pkt_is_read[k])
		);
	end

	// read responses first, round robin inside each class
	resp_scheduler i_resp_scheduler (
		.to                (to),
		.rst_n             (rst_n),
		.pkt_ready         (pkt_ready),
		.pkt_is_read       (pkt_is_read),
		.head              (head),
		.pop               (pop),
		.noc_from_dev_ctl  (noc_from_dev_ctl),
		.noc_from_dev_data (noc_from_dev_data)
	);

endmodule

`default_nettype wire

// File: source/dest_router.sv
`timescale 1ns/1ns
`default_nettype none

module dest_router import switch_pkg::*; (
	input wire logic to,
	input wire logic rst_n,
	input wire logic noc_to_dev_ctl,
	input wire logic [BYTE_W-1:0] noc_to_dev_data,
	output logic [NUM_PORTS-1:0] dev_tx_ctl,
	output logic [NUM_PORTS-1:0][BYTE_W-1:0] dev_tx_data
);

	route_state_e state;
	port_sel_t sel;
	port_sel_t dest_dec;
	flit_t in_flit;
	flit_t dly1;
	flit_t dly2;

	assign in_flit = {noc_to_dev_ctl, noc_to_dev_data};

	// one-hot decode of the incoming byte, zero when outside the id range
	always_comb begin
		for (int k = 0; k < NUM_PORTS; k++) begin
			dest_dec[k] = (noc_to_dev_data == DEV_ID_BASE + BYTE_W'(k));
		end
	end

	// command, then destination, then forward until the closing nop
	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			state <= rt_wait_cmd;
			sel <= '0;
		end else begin
			case (state)
				rt_wait_cmd: begin
					if (is_cmd(in_flit)) begin
						// old packet has already left the delay line
						sel <= '0;
						state <= rt_wait_dest;
					end
				end
				rt_wait_dest: begin
					if (!in_flit.ctl) begin
						// latched while the command sits in stage one
						sel <= dest_dec;
						state <= rt_forward;
					end else if (is_nop(in_flit)) begin
						state <= rt_wait_cmd;
					end
				end
				rt_forward: begin
					if (is_cmd(in_flit)) begin
						sel <= '0;
						state <= rt_wait_dest;
					end else if (is_nop(in_flit)) begin
						state <= rt_wait_cmd;
					end
				end
				default: state <= rt_wait_cmd;
			endcase
		end
	end

	// two stage delay, sel never routes stale contents
	always_ff @(posedge to) begin
		dly1 <= in_flit;
		dly2 <= dly1;
	end

	// delayed byte on the selected port, nop everywhere else
	always_comb begin
		for (int k = 0; k < NUM_PORTS; k++) begin
			dev_tx_ctl[k] = sel[k] ? dly2.ctl : 1'b1;
			dev_tx_data[k] = sel[k] ? dly2.data : NOP_DATA;
		end
	end

endmodule

`default_nettype wire

// File: arbiter/resp_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module resp_scheduler import switch_pkg::*; (
	input wire logic to,
	input wire logic rst_n,
	input wire port_sel_t pkt_ready,
	input wire port_sel_t pkt_is_read,
	input wire flit_t [NUM_PORTS-1:0] head,
	output port_sel_t pop,
	output logic noc_from_dev_ctl,
	output logic [BYTE_W-1:0] noc_from_dev_data
);

	sched_state_e state;
	port_sel_t req_hi;
	port_sel_t req_lo;
	port_sel_t grant_hi;
	port_sel_t grant_lo;
	port_sel_t grant_q;
	logic adv_hi;
	logic adv_lo;
	flit_t cur;

	// two classes, read responses and everything else
	assign req_hi = pkt_ready & pkt_is_read;
	assign req_lo = pkt_ready & ~pkt_is_read;

	// low class only advances when no read response is waiting
	assign adv_hi = (state == sc_pick) && (|req_hi);
	assign adv_lo = (state == sc_pick) && !(|req_hi) && (|req_lo);

	rr_arbiter i_arb_hi (
		.to      (to),
		.rst_n   (rst_n),
		.req     (req_hi),
		.advance (adv_hi),
		.grant   (grant_hi)
	);

	rr_arbiter i_arb_lo (
		.to      (to),
		.rst_n   (rst_n),
		.req     (req_lo),
		.advance (adv_lo),
		.grant   (grant_lo)
	);

	// head flit of the granted queue
	always_comb begin
		cur = {1'b1, NOP_DATA};
		for (int k = 0; k < NUM_PORTS; k++) begin
			if (grant_q[k]) cur = head[k];
		end
	end

	// one flit per cycle out of the granted queue
	assign pop = (state == sc_drain) ? grant_q : '0;

	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			state <= sc_pick;
			grant_q <= '0;
			noc_from_dev_ctl <= 1'b1;
			noc_from_dev_data <= NOP_DATA;
		end else begin
			case (state)
				sc_pick: begin
					// idle line while deciding
					noc_from_dev_ctl <= 1'b1;
					noc_from_dev_data <= NOP_DATA;
					if (adv_hi) begin
						grant_q <= grant_hi;
						state <= sc_drain;
					end else if (adv_lo) begin
						grant_q <= grant_lo;
						state <= sc_drain;
					end
				end
				sc_drain: begin
					noc_from_dev_ctl <= cur.ctl;
					noc_from_dev_data <= cur.data;
					// the closing nop ends this grant
					if (is_nop(cur)) begin
						grant_q <= '0;
						state <= sc_pick;
					end
				end
				default: state <= sc_pick;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: arbiter/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter import switch_pkg::*; (
	input wire logic to,
	input wire logic rst_n,
	input wire port_sel_t req,
	input wire logic advance,
	output port_sel_t grant
);

	// ptr names the port with top priority
	logic [PORT_W-1:0] ptr;
	logic [PORT_W-1:0] idx;
	logic [PORT_W-1:0] grant_idx;
	logic found;

	// search upward from ptr, wrapping, first request wins
	always_comb begin
		grant = '0;
		grant_idx = ptr;
		found = 1'b0;
		idx = ptr;
		for (int i = 0; i < NUM_PORTS; i++) begin
			idx = ptr + PORT_W'(i);
			if (!found && req[idx]) begin
				grant[idx] = 1'b1;
				grant_idx = idx;
				found = 1'b1;
			end
		end
	end

	// rotate past the winner only when this class was used
	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (advance && found) begin
			ptr <= grant_idx + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: resp_queue/resp_queue.sv
`timescale 1ns/1ns
`default_nettype none

module resp_queue import switch_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input wire logic to,
	input wire logic rst_n,
	input wire logic dev_rx_ctl,
	input wire logic [BYTE_W-1:0] dev_rx_data,
	input wire logic pop,
	output flit_t head,
	output logic pkt_ready,
	output logic pkt_is_read
);

	// room for one packet per two entries at most
	localparam int CW = $clog2(FIFO_DEPTH) + 1;

	frame_state_e state;
	flit_t rx_flit;
	logic wr;
	logic full;
	logic empty;
	logic nop_in;
	logic nop_out;
	logic [CW-1:0] pkt_cnt;

	assign rx_flit = {dev_rx_ctl, dev_rx_data};

	// outside a packet only a command byte is kept
	always_comb begin
		case (state)
			fr_idle: wr = is_cmd(rx_flit);
			fr_store: wr = 1'b1;
			default: wr = 1'b0;
		endcase
	end

	// framing, a dropped command leaves us idle so its payload is skipped too
	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			state <= fr_idle;
		end else begin
			case (state)
				fr_idle: if (is_cmd(rx_flit) && !full) state <= fr_store;
				fr_store: if (is_nop(rx_flit)) state <= fr_idle;
				default: state <= fr_idle;
			endcase
		end
	end

	flit_fifo #(
		.DEPTH (FIFO_DEPTH)
	) i_flit_fifo (
		.to    (to),
		.rst_n (rst_n),
		.wr    (wr),
		.wdata (rx_flit),
		.rd    (pop),
		.rdata (head),
		.full  (full),
		.empty (empty)
	);

	// complete packets held, counted by their closing nop
	assign nop_in = wr && !full && is_nop(rx_flit);
	assign nop_out = pop && !empty && is_nop(head);

	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			pkt_cnt <= '0;
		end else if (nop_in && !nop_out) begin
			pkt_cnt <= pkt_cnt + 1'b1;
		end else if (!nop_in && nop_out) begin
			pkt_cnt <= pkt_cnt - 1'b1;
		end
	end

	assign pkt_ready = (pkt_cnt != '0);
	// head is a command byte whenever a packet waits
	assign pkt_is_read = head.ctl && (noc_op_e'(head.data[2:0]) == op_read_resp);

endmodule

`default_nettype wire

// File: resp_queue/flit_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module flit_fifo import switch_pkg::*; #(
	parameter int DEPTH = 16
) (
	input wire logic to,
	input wire logic rst_n,
	input wire logic wr,
	input wire flit_t wdata,
	input wire logic rd,
	output flit_t rdata,
	output logic full,
	output logic empty
);

	localparam int AW = $clog2(DEPTH);

	flit_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	// a write into a full buffer is lost, a read of an empty one does nothing
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign full = (count == (AW+1)'(DEPTH));
	assign empty = (count == '0);

	// show-ahead, head entry visible without a read
	assign rdata = mem[rd_ptr];

	always_ff @(posedge to) begin
		if (do_wr) mem[wr_ptr] <= wdata;
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge to or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd) count <= count + 1'b1;
			else if (!do_wr && do_rd) count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: common/switch_pkg.sv
`default_nettype none

package switch_pkg;

	// stream byte width and number of device ports
	localparam int BYTE_W = 8;
	localparam int NUM_PORTS = 4;
	localparam int PORT_W = $clog2(NUM_PORTS);

	// port k answers to id DEV_ID_BASE + k
	localparam logic [BYTE_W-1:0] DEV_ID_BASE = 8'h40;

	// data value carried by a nop (ctl stays high)
	localparam logic [BYTE_W-1:0] NOP_DATA = '0;

	// one stream element, ctl sits above the byte
	typedef struct packed {
		logic ctl;
		logic [BYTE_W-1:0] data;
	} flit_t;

	// one bit per device port
	typedef logic [NUM_PORTS-1:0] port_sel_t;

	// opcode field in the low bits of a command byte
	typedef enum logic [2:0] {
		op_none       = 3'b000,
		op_read       = 3'b001,
		op_write      = 3'b010,
		op_read_resp  = 3'b011,
		op_write_resp = 3'b100,
		op_message    = 3'b101
	} noc_op_e;

	typedef enum logic [1:0] {rt_wait_cmd, rt_wait_dest, rt_forward} route_state_e;
	typedef enum logic {fr_idle, fr_store} frame_state_e;
	typedef enum logic {sc_pick, sc_drain} sched_state_e;

	// ctl high with nonzero data opens a packet
	function automatic logic is_cmd(flit_t f);
		return f.ctl && (f.data != NOP_DATA);
	endfunction

	// ctl high with zero data closes a packet or idles the line
	function automatic logic is_nop(flit_t f);
		return f.ctl && (f.data == NOP_DATA);
	endfunction

endpackage

`default_nettype wire
